// File: source/rayPkg.sv
package rayPkg;

    //////////////////////////////////////////////////
    // Ray field widths

    localparam int coordWidth = 28;                 // One origin coordinate.
    localparam int dirCompWidth = 16;               // One direction component.
    localparam int dirWidth = 3 * dirCompWidth;     // Three packed components, 48 bits.

    //////////////////////////////////////////////////
    // Register-group bus

    localparam int busWidth = 32;
    localparam int slotAddrWidth = 4;
    localparam int slotCount = 2 ** slotAddrWidth;  // Sixteen ray slots.

    // Word select carried on rgWE. The high direction word has the middle
    // component in its upper half and the top component in its lower half.
    typedef enum logic [2:0]
    {
        wordNone    = 3'd0,
        wordOrigX   = 3'd1,
        wordOrigY   = 3'd2,
        wordOrigZ   = 3'd3,
        wordDirHigh = 3'd4,
        wordDirLow  = 3'd5
    } rgWordSel;

    //////////////////////////////////////////////////
    // Sender state codes shown on statepeek

    localparam logic [2:0] peekIdle        = 3'd1;
    localparam logic [2:0] peekWaitX       = 3'd2;
    localparam logic [2:0] peekWaitY       = 3'd3;
    localparam logic [2:0] peekWaitZ       = 3'd4;
    localparam logic [2:0] peekWaitDirHigh = 3'd5;
    localparam logic [2:0] peekWaitDirLow  = 3'd6;
    localparam logic [2:0] peekGap         = 3'd7;

endpackage

// File: source/raySend.sv
`timescale 1ns/10ps

module raySend
    import rayPkg::*;
(
    input  logic                     clk,
    input  logic                     globalreset,
    input  logic                     as,
    output logic                     ack,
    input  logic [slotAddrWidth-1:0] addr,
    input  logic [coordWidth-1:0]    origx,
    input  logic [coordWidth-1:0]    origy,
    input  logic [coordWidth-1:0]    origz,
    input  logic [dirWidth-1:0]      dir,
    output logic [busWidth-1:0]      rgData,
    output logic [slotAddrWidth-1:0] rgAddr,
    output rgWordSel                 rgWE,
    output logic                     rgAddrValid,
    input  logic                     rgDone,
    output logic [2:0]               statepeek
);

    typedef enum logic [3:0]
    {
        stIdle,
        stWaitX,
        stWaitY,
        stWaitZ,
        stWaitDirHigh,
        stWaitDirLow,
        stGapY,
        stGapZ,
        stGapDirHigh,
        stGapDirLow
    } sendState;

    sendState state;
    sendState nextState;

    logic [busWidth-1:0]      nextRgData;
    logic [slotAddrWidth-1:0] nextRgAddr;
    rgWordSel                 nextRgWE;
    logic                     nextRgAddrValid;
    logic                     nextAck;

    logic [busWidth-1:0] origXWord;
    logic [busWidth-1:0] origYWord;
    logic [busWidth-1:0] origZWord;
    logic [busWidth-1:0] dirHighWord;
    logic [busWidth-1:0] dirLowWord;

    assign origXWord = busWidth'(origx);
    assign origYWord = busWidth'(origy);
    assign origZWord = busWidth'(origz);
    assign dirHighWord = {dir[2*dirCompWidth-1:dirCompWidth], dir[dirWidth-1:2*dirCompWidth]};
    assign dirLowWord = busWidth'(dir[dirCompWidth-1:0]);

    //////////////////////////////////////////////////
    // Next-state and bus load logic

    always_comb
    begin
        nextState = state;
        nextRgData = rgData;                        // Bus registers hold between loads.
        nextRgAddr = rgAddr;
        nextRgWE = rgWE;
        nextRgAddrValid = rgAddrValid;
        nextAck = ack;
        statepeek = peekGap;
        case (state)
            stIdle:
            begin
                statepeek = peekIdle;
                if (as && !ack)
                begin
                    nextState = stWaitX;
                    nextRgData = origXWord;
                    nextRgWE = wordOrigX;
                    nextRgAddrValid = 1'b1;
                    nextRgAddr = addr;              // Slot is captured once per ray.
                end
                else if (!as && ack)
                begin
                    nextAck = 1'b0;
                end
            end
            stWaitX:
            begin
                statepeek = peekWaitX;
                if (rgDone)
                begin
                    nextState = stGapY;
                    nextRgAddrValid = 1'b0;
                end
            end
            stWaitY:
            begin
                statepeek = peekWaitY;
                if (rgDone)
                begin
                    nextState = stGapZ;
                    nextRgAddrValid = 1'b0;
                end
            end
            stWaitZ:
            begin
                statepeek = peekWaitZ;
                if (rgDone)
                begin
                    nextState = stGapDirHigh;
                    nextRgAddrValid = 1'b0;
                end
            end
            stWaitDirHigh:
            begin
                statepeek = peekWaitDirHigh;
                if (rgDone)
                begin
                    nextState = stGapDirLow;
                    nextRgAddrValid = 1'b0;
                end
            end
            stWaitDirLow:
            begin
                statepeek = peekWaitDirLow;
                nextAck = 1'b1;                     // Last word is on the bus.
                if (rgDone)
                begin
                    nextState = stIdle;
                    nextRgAddrValid = 1'b0;
                end
            end
            stGapY:
            begin
                nextState = stWaitY;
                nextRgData = origYWord;
                nextRgWE = wordOrigY;
                nextRgAddrValid = 1'b1;
            end
            stGapZ:
            begin
                nextState = stWaitZ;
                nextRgData = origZWord;
                nextRgWE = wordOrigZ;
                nextRgAddrValid = 1'b1;
            end
            stGapDirHigh:
            begin
                nextState = stWaitDirHigh;
                nextRgData = dirHighWord;
                nextRgWE = wordDirHigh;
                nextRgAddrValid = 1'b1;
            end
            stGapDirLow:
            begin
                nextState = stWaitDirLow;
                nextRgData = dirLowWord;
                nextRgWE = wordDirLow;
                nextRgAddrValid = 1'b1;
            end
            default:
            begin
                nextState = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge globalreset)
    begin
        if (globalreset)
        begin
            state <= stIdle;
            ack <= 1'b0;
            rgWE <= wordNone;
            rgAddrValid <= 1'b0;
        end
        else
        begin
            state <= nextState;
            ack <= nextAck;
            rgWE <= nextRgWE;
            rgAddrValid <= nextRgAddrValid;
        end
    end

    always_ff @(posedge clk)
    begin
        rgData <= nextRgData;
        rgAddr <= nextRgAddr;
    end

    //////////////////////////////////////////////////
    // Bus protocol checks

    assert property (@(posedge clk) disable iff (globalreset)
        rgAddrValid && !rgDone |=> rgAddrValid)
        else $error("raySend: rgAddrValid fell without rgDone");

    assert property (@(posedge clk) disable iff (globalreset)
        rgAddrValid && !rgDone |=> $stable(rgWE) && $stable(rgData) && $stable(rgAddr))
        else $error("raySend: bus word changed while rgAddrValid was high");

endmodule

// File: source/rayBusTarget.sv
`timescale 1ns/10ps

module rayBusTarget
    import rayPkg::*;
#(
    parameter int doneLatency = 1
)
(
    input  logic                     clk,
    input  logic                     globalreset,
    input  logic [busWidth-1:0]      rgData,
    input  logic [slotAddrWidth-1:0] rgAddr,
    input  rgWordSel                 rgWE,
    input  logic                     rgAddrValid,
    output logic                     rgDone,
    output logic                     storeWrite,
    output logic [slotAddrWidth-1:0] storeAddr,
    output rgWordSel                 storeSel,
    output logic [busWidth-1:0]      storeData
);

    localparam int latency = (doneLatency < 1) ? 1 : doneLatency;   // At least one cycle.
    localparam int countWidth = $clog2(latency + 1);
    localparam logic [countWidth-1:0] lastCount = countWidth'(latency - 1);
    localparam logic [countWidth-1:0] spentCount = countWidth'(latency);

    logic [countWidth-1:0] waitCount;
    logic                  accept;
    logic                  acceptPulse;

    // The counter saturates once the word is taken, so one word gives one pulse.
    assign accept = rgAddrValid && (waitCount == lastCount);

    always_ff @(posedge clk or posedge globalreset)
    begin
        if (globalreset)
        begin
            waitCount <= '0;
            acceptPulse <= 1'b0;
        end
        else
        begin
            acceptPulse <= accept;
            if (!rgAddrValid)
            begin
                waitCount <= '0;                    // Restart on every bus gap.
            end
            else if (waitCount != spentCount)
            begin
                waitCount <= waitCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            storeAddr <= rgAddr;
            storeSel <= rgWE;
            storeData <= rgData;
        end
    end

    assign rgDone = acceptPulse;
    assign storeWrite = acceptPulse;                // Store write lands with rgDone.

    //////////////////////////////////////////////////
    // Done pulse checks

    assert property (@(posedge clk) disable iff (globalreset)
        rgDone |=> !rgDone)
        else $error("rayBusTarget: rgDone high in two consecutive cycles");

    assert property (@(posedge clk) disable iff (globalreset)
        rgDone |-> rgAddrValid)
        else $error("rayBusTarget: rgDone while rgAddrValid was low");

endmodule

// File: source/rayStore.sv
`timescale 1ns/10ps

module rayStore
    import rayPkg::*;
(
    input  logic                     clk,
    input  logic                     globalreset,
    input  logic                     storeWrite,
    input  logic [slotAddrWidth-1:0] storeAddr,
    input  rgWordSel                 storeSel,
    input  logic [busWidth-1:0]      storeData,
    input  logic [slotAddrWidth-1:0] readAddr,
    output logic [coordWidth-1:0]    readOrigX,
    output logic [coordWidth-1:0]    readOrigY,
    output logic [coordWidth-1:0]    readOrigZ,
    output logic [dirWidth-1:0]      readDir,
    output logic                     readValid
);

    logic [coordWidth-1:0]     origXMem [slotCount];
    logic [coordWidth-1:0]     origYMem [slotCount];
    logic [coordWidth-1:0]     origZMem [slotCount];
    logic [2*dirCompWidth-1:0] dirHighMem [slotCount];  // Top and middle components.
    logic [dirCompWidth-1:0]   dirLowMem [slotCount];

    logic [slotCount-1:0]      slotComplete;
    logic [2*dirCompWidth-1:0] dirHighField;

    // Undo the word order, top component first.
    assign dirHighField = {storeData[dirCompWidth-1:0],
                           storeData[2*dirCompWidth-1:dirCompWidth]};

    //////////////////////////////////////////////////
    // Slot memory

    always_ff @(posedge clk)
    begin
        if (storeWrite)
        begin
            case (storeSel)
                wordOrigX:   origXMem[storeAddr] <= storeData[coordWidth-1:0];
                wordOrigY:   origYMem[storeAddr] <= storeData[coordWidth-1:0];
                wordOrigZ:   origZMem[storeAddr] <= storeData[coordWidth-1:0];
                wordDirHigh: dirHighMem[storeAddr] <= dirHighField;
                wordDirLow:  dirLowMem[storeAddr] <= storeData[dirCompWidth-1:0];
                default:     ;
            endcase
        end
    end

    // A ray opens with its X word and is whole after its low direction word.
    always_ff @(posedge clk or posedge globalreset)
    begin
        if (globalreset)
        begin
            slotComplete <= '0;
        end
        else if (storeWrite)
        begin
            if (storeSel == wordDirLow)
            begin
                slotComplete[storeAddr] <= 1'b1;
            end
            else if (storeSel == wordOrigX)
            begin
                slotComplete[storeAddr] <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Registered read port

    always_ff @(posedge clk)
    begin
        readOrigX <= origXMem[readAddr];
        readOrigY <= origYMem[readAddr];
        readOrigZ <= origZMem[readAddr];
        readDir <= {dirHighMem[readAddr], dirLowMem[readAddr]};
    end

    always_ff @(posedge clk or posedge globalreset)
    begin
        if (globalreset)
        begin
            readValid <= 1'b0;
        end
        else
        begin
            readValid <= slotComplete[readAddr];
        end
    end

    assert property (@(posedge clk) disable iff (globalreset)
        storeWrite |-> storeSel != wordNone)
        else $error("rayStore: store write without a word select");

endmodule

// File: source/rayTop.sv
`timescale 1ns/10ps

module rayTop
    import rayPkg::*;
#(
    parameter int doneLatency = 2
)
(
    input  logic                     clk,
    input  logic                     globalreset,
    input  logic                     as,
    output logic                     ack,
    input  logic [slotAddrWidth-1:0] addr,
    input  logic [coordWidth-1:0]    origx,
    input  logic [coordWidth-1:0]    origy,
    input  logic [coordWidth-1:0]    origz,
    input  logic [dirWidth-1:0]      dir,
    output logic [2:0]               statepeek,
    input  logic [slotAddrWidth-1:0] readAddr,
    output logic [coordWidth-1:0]    readOrigX,
    output logic [coordWidth-1:0]    readOrigY,
    output logic [coordWidth-1:0]    readOrigZ,
    output logic [dirWidth-1:0]      readDir,
    output logic                     readValid
);

    logic [busWidth-1:0]      rgData;
    logic [slotAddrWidth-1:0] rgAddr;
    rgWordSel                 rgWE;
    logic                     rgAddrValid;
    logic                     rgDone;

    logic                     storeWrite;
    logic [slotAddrWidth-1:0] storeAddr;
    rgWordSel                 storeSel;
    logic [busWidth-1:0]      storeData;

    //////////////////////////////////////////////////
    // Bus master, target and ray store

    raySend sender
    (
        .clk         (clk),
        .globalreset (globalreset),
        .as          (as),
        .ack         (ack),
        .addr        (addr),
        .origx       (origx),
        .origy       (origy),
        .origz       (origz),
        .dir         (dir),
        .rgData      (rgData),
        .rgAddr      (rgAddr),
        .rgWE        (rgWE),
        .rgAddrValid (rgAddrValid),
        .rgDone      (rgDone),
        .statepeek   (statepeek)
    );

    rayBusTarget #(.doneLatency(doneLatency)) target
    (
        .clk         (clk),
        .globalreset (globalreset),
        .rgData      (rgData),
        .rgAddr      (rgAddr),
        .rgWE        (rgWE),
        .rgAddrValid (rgAddrValid),
        .rgDone      (rgDone),
        .storeWrite  (storeWrite),
        .storeAddr   (storeAddr),
        .storeSel    (storeSel),
        .storeData   (storeData)
    );

    rayStore store
    (
        .clk         (clk),
        .globalreset (globalreset),
        .storeWrite  (storeWrite),
        .storeAddr   (storeAddr),
        .storeSel    (storeSel),
        .storeData   (storeData),
        .readAddr    (readAddr),
        .readOrigX   (readOrigX),
        .readOrigY   (readOrigY),
        .readOrigZ   (readOrigZ),
        .readDir     (readDir),
        .readValid   (readValid)
    );

endmodule

// File: verif/tbRay.sv
`timescale 1ns/10ps

module tbRay
    import rayPkg::*;
();

    localparam int tbLatency = 3;
    localparam int maxRays = 40;
    localparam int cyclesPerRay = 40;
    localparam int cycleLimit = maxRays * cyclesPerRay;
    localparam logic [2:0] idleCode = 3'd1;

    logic                     clk;
    logic                     globalreset;
    logic                     as;
    logic                     ack;
    logic [slotAddrWidth-1:0] addr;
    logic [coordWidth-1:0]    origx;
    logic [coordWidth-1:0]    origy;
    logic [coordWidth-1:0]    origz;
    logic [dirWidth-1:0]      dir;
    logic [2:0]               statepeek;
    logic [slotAddrWidth-1:0] readAddr;
    logic [coordWidth-1:0]    readOrigX;
    logic [coordWidth-1:0]    readOrigY;
    logic [coordWidth-1:0]    readOrigZ;
    logic [dirWidth-1:0]      readDir;
    logic                     readValid;

    // Reference model of every slot, filled as rays are acknowledged.
    logic [coordWidth-1:0] modelX [slotCount];
    logic [coordWidth-1:0] modelY [slotCount];
    logic [coordWidth-1:0] modelZ [slotCount];
    logic [dirWidth-1:0]   modelDir [slotCount];
    logic                  modelValid [slotCount];

    logic                  checkEn;
    logic                  expValid;
    logic [coordWidth-1:0] expOrigX;
    logic [coordWidth-1:0] expOrigY;
    logic [coordWidth-1:0] expOrigZ;
    logic [dirWidth-1:0]   expDir;

    integer seed;
    int     errorCount = 0;
    int     cycleCount = 0;

    rayTop #(.doneLatency(tbLatency)) dut
    (
        .clk         (clk),
        .globalreset (globalreset),
        .as          (as),
        .ack         (ack),
        .addr        (addr),
        .origx       (origx),
        .origy       (origy),
        .origz       (origz),
        .dir         (dir),
        .statepeek   (statepeek),
        .readAddr    (readAddr),
        .readOrigX   (readOrigX),
        .readOrigY   (readOrigY),
        .readOrigZ   (readOrigZ),
        .readDir     (readDir),
        .readValid   (readValid)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Handshake and state checks

    assert property (@(posedge clk) $fell(globalreset) |-> ack == 1'b0)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: ack = %b after reset, expected 0", $time, $sampled(ack));
        end

    assert property (@(posedge clk) disable iff (globalreset) $rose(ack) |-> $past(as) == 1'b1)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: as = %b when ack rose, expected 1", $time, $past(as));
        end

    assert property (@(posedge clk) disable iff (globalreset) ack && as |=> ack == 1'b1)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: ack = %b while as held, expected 1", $time, $sampled(ack));
        end

    assert property (@(posedge clk) disable iff (globalreset) $fell(ack) |-> $past(as) == 1'b0)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: as = %b before ack fell, expected 0", $time, $past(as));
        end

    assert property (@(posedge clk) disable iff (globalreset)
        !ack && !as |-> statepeek == idleCode)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: statepeek = %0d, expected %0d", $time,
                $sampled(statepeek), idleCode);
        end

    //////////////////////////////////////////////////
    // Read-back checks

    assert property (@(posedge clk) disable iff (globalreset) checkEn |-> readValid == expValid)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: readValid = %b, expected %b (slot %0d)", $time,
                $sampled(readValid), expValid, readAddr);
        end

    assert property (@(posedge clk) disable iff (globalreset)
        checkEn && expValid |-> readOrigX == expOrigX)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: readOrigX = %h, expected %h", $time,
                $sampled(readOrigX), expOrigX);
        end

    assert property (@(posedge clk) disable iff (globalreset)
        checkEn && expValid |-> readOrigY == expOrigY)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: readOrigY = %h, expected %h", $time,
                $sampled(readOrigY), expOrigY);
        end

    assert property (@(posedge clk) disable iff (globalreset)
        checkEn && expValid |-> readOrigZ == expOrigZ)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: readOrigZ = %h, expected %h", $time,
                $sampled(readOrigZ), expOrigZ);
        end

    assert property (@(posedge clk) disable iff (globalreset)
        checkEn && expValid |-> readDir == expDir)
        else begin
            errorCount = errorCount + 1;
            $display("Error at %0t: readDir = %h, expected %h", $time,
                $sampled(readDir), expDir);
        end

    //////////////////////////////////////////////////
    // Stimulus

    task automatic sendRay(input logic [slotAddrWidth-1:0] slot,
        input logic [coordWidth-1:0] x, input logic [coordWidth-1:0] y,
        input logic [coordWidth-1:0] z, input logic [dirWidth-1:0] d, input int holdCycles);
        @(posedge clk);
        #1;
        addr = slot;
        origx = x;
        origy = y;
        origz = z;
        dir = d;
        as = 1'b1;
        while (!ack)
        begin
            @(posedge clk);
            #1;
        end
        repeat (holdCycles)
        begin
            @(posedge clk);
            #1;
        end
        as = 1'b0;                                  // Producer lets go a few cycles after ack.
        modelX[slot] = x;
        modelY[slot] = y;
        modelZ[slot] = z;
        modelDir[slot] = d;
        modelValid[slot] = 1'b1;
        while (ack)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic sendRandomRay(input logic [slotAddrWidth-1:0] slot);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        r4 = $random(seed);
        r5 = $random(seed);
        sendRay(slot, r0[coordWidth-1:0], r1[coordWidth-1:0], r2[coordWidth-1:0],
            {r3[15:0], r4}, int'(r5[1:0]));
    endtask

    // Read data arrives one cycle after readAddr, and is compared the cycle after that.
    task automatic checkSlot(input logic [slotAddrWidth-1:0] slot);
        @(posedge clk);
        #1;
        readAddr = slot;
        @(posedge clk);
        #1;
        expValid = modelValid[slot];
        expOrigX = modelX[slot];
        expOrigY = modelY[slot];
        expOrigZ = modelZ[slot];
        expDir = modelDir[slot];
        checkEn = 1'b1;
        @(posedge clk);
        #1;
        checkEn = 1'b0;
    endtask

    task automatic checkAllSlots();
        for (int i = 0; i < slotCount; i++)
        begin
            checkSlot(slotAddrWidth'(i));
        end
    endtask

    initial
    begin
        logic [31:0] pick;
        seed = 33;
        globalreset = 1'b1;
        as = 1'b0;
        addr = '0;
        origx = '0;
        origy = '0;
        origz = '0;
        dir = '0;
        readAddr = '0;
        checkEn = 1'b0;
        expValid = 1'b0;
        expOrigX = '0;
        expOrigY = '0;
        expOrigZ = '0;
        expDir = '0;
        for (int i = 0; i < slotCount; i++)
        begin
            modelValid[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        globalreset = 1'b0;

        checkAllSlots();                            // Nothing is valid after reset.
        sendRay(4'd5, 28'h0ABCDEF, 28'h1234567, 28'hFEDCBA9, 48'hA1B2_C3D4_E5F6, 0);
        checkAllSlots();
        sendRandomRay(4'd5);                        // Overwrite of the same slot.
        checkSlot(4'd5);
        for (int i = 0; i < slotCount; i++)
        begin
            sendRandomRay(slotAddrWidth'(i));
        end
        checkAllSlots();
        for (int i = 0; i < 12; i++)
        begin
            pick = $random(seed);
            sendRandomRay(pick[slotAddrWidth-1:0]);
        end
        checkAllSlots();
        repeat (2) @(posedge clk);

        $display("Errors: %0d, timeouts: 0", errorCount);
        if (errorCount == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == cycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Errors: %0d, timeouts: 1", errorCount);
            $display("** FAIL **");
            $finish;
        end
    end

endmodule

// File: build.f
source/rayPkg.sv
source/raySend.sv
source/rayBusTarget.sv
source/rayStore.sv
source/rayTop.sv
verif/tbRay.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbRay -f build.f -o simRay
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simRay > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0
